//--- off_link_bridge.f
verilog/off_link_pkg.sv
verilog/link_fsm_pkg.sv
verilog/async_fifo_fwft.sv
verilog/off_link_ctrl.sv
verilog/core_link_ctrl.sv
verilog/off_link_bridge.sv
test/tb_off_link_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the off-chip link bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_off_link_bridge \
    -f off_link_bridge.f -o tb_off_link_bridge
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_off_link_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- test/tb_off_link_bridge.sv
// Testbench for the off-chip link bridge
// Runs a table of inbound and outbound frames through the DUT and checks
// routing, beat order, last and command flags, and back-pressure

`timescale 1ns/1ps

module tb_off_link_bridge;

    typedef off_link_pkg::link_dat_t   dat_t;
    typedef off_link_pkg::fifo_entry_t entry_t;

    localparam int TIMEOUT = 2000;
    // Frame sources
    localparam int OFF_CCU = 0;
    localparam int OFF_GIC = 1;
    localparam int GIC     = 2;
    localparam int MON     = 3;
    localparam int MON_GIC = 4;
    localparam bit DIR_IN  = 1'b0;
    localparam bit DIR_OUT = 1'b1;
    // Base offset of the gic frame in the monitor priority row
    localparam dat_t GIC_OFS = 32'h0100_0000;

    logic OffClk = 1'b0;
    logic core_clk = 1'b0;
    logic rst_n;
    dat_t off_dat_i, gic_dat_i, mon_dat_i, off_dat_o, ccu_dat_o, gic_dat_o;
    logic off_dat_vld_i, off_dat_last_i, off_isa_vld_i, off_dat_rdy_o;
    logic off_dat_vld_o, off_dat_last_o, off_cmd_vld_o, off_dat_oe_o;
    logic off_dat_rdy_i = 1'b1;
    logic ccu_dat_rdy_i = 1'b1;
    logic gic_dat_rdy_i = 1'b1;
    logic ccu_dat_vld_o, ccu_dat_last_o, gic_dat_vld_o, gic_dat_last_o;
    logic gic_dat_vld_i, gic_dat_last_i, gic_cmd_vld_i, gic_dat_rdy_o;
    logic mon_dat_vld_i, mon_dat_last_i, mon_dat_rdy_o;

    // Frame table with one entry per row in each queue
    string t_name[$];
    bit    t_dir[$];
    int    t_src[$];
    int    t_beats[$];
    dat_t  t_base[$];
    bit    t_cmd[$];
    bit    t_bp[$];

    entry_t     ccu_q[$], gic_q[$], off_q[$];
    int         ccu_vld_cnt = 0;
    int         gic_vld_cnt = 0;
    int         oe_bad_cnt = 0;
    logic [2:0] bp_pat[$];
    integer     seed;
    bit         bp_en = 1'b0;
    int         err_cnt, tests_run, tests_failed;
    string      cur_name;

    off_link_bridge i_off_link_bridge (.*);

    initial begin
        forever #10 OffClk = ~OffClk;
    end

    // Core clock at 14 ns is not a multiple of the 20 ns OffClk, so both
    // FIFOs cross a real asynchronous boundary. The 3 ns offset keeps the
    // falling edges of the two clocks apart
    initial begin
        #3;
        forever #7 core_clk = ~core_clk;
    end

    // ------------------------------------------------------------------------
    // Ready patterns for back-pressure rows

    initial begin
        seed = 32'h7170a3a5;
        for (int i = 0; i < 1024; i++) begin
            bp_pat.push_back(3'($random(seed)));
        end
    end

    initial begin : off_ready_gen
        int k;
        k = 0;
        forever begin
            @(negedge OffClk);
            off_dat_rdy_i = bp_en ? bp_pat[k % 1024][0] : 1'b1;
            k++;
        end
    end

    initial begin : core_ready_gen
        int k;
        k = 512;
        forever begin
            @(negedge core_clk);
            ccu_dat_rdy_i = bp_en ? bp_pat[k % 1024][1] : 1'b1;
            gic_dat_rdy_i = bp_en ? bp_pat[k % 1024][2] : 1'b1;
            k++;
        end
    end

    // ------------------------------------------------------------------------
    // Monitors sample just after the falling edge

    initial begin : off_monitor
        forever begin
            @(negedge OffClk);
            #1;
            if (off_dat_oe_o !== off_dat_vld_o) begin
                oe_bad_cnt++;
            end
            if (off_dat_vld_o && off_dat_rdy_i) begin
                off_q.push_back({off_dat_o, off_cmd_vld_o, off_dat_last_o});
            end
        end
    end

    initial begin : core_monitor
        forever begin
            @(negedge core_clk);
            #1;
            if (ccu_dat_vld_o) ccu_vld_cnt++;
            if (gic_dat_vld_o) gic_vld_cnt++;
            if (ccu_dat_vld_o && ccu_dat_rdy_i) begin
                ccu_q.push_back({ccu_dat_o, 1'b0, ccu_dat_last_o});
            end
            if (gic_dat_vld_o && gic_dat_rdy_i) begin
                gic_q.push_back({gic_dat_o, 1'b0, gic_dat_last_o});
            end
        end
    end

    // ------------------------------------------------------------------------
    // Helpers

    task automatic check_value(input string what, input entry_t exp, input entry_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input int errs0);
        tests_run++;
        if (err_cnt != errs0) begin
            tests_failed++;
            $display("Test %-16s failed", cur_name);
        end else begin
            $display("Test %-16s ok", cur_name);
        end
    endtask

    task automatic add_row(input string name, input bit dir, input int src, input int beats,
                           input dat_t base, input bit cmd, input bit bp);
        t_name.push_back(name);
        t_dir.push_back(dir);
        t_src.push_back(src);
        t_beats.push_back(beats);
        t_base.push_back(base);
        t_cmd.push_back(cmd);
        t_bp.push_back(bp);
    endtask

    function automatic int collected_count(input int src);
        if (src == OFF_CCU) return ccu_q.size();
        if (src == OFF_GIC) return gic_q.size();
        return off_q.size();
    endfunction

    function automatic entry_t beat_at(input int src, input int idx);
        if (src == OFF_CCU) return ccu_q[idx];
        if (src == OFF_GIC) return gic_q[idx];
        return off_q[idx];
    endfunction

    // Off-chip sender holds each beat until the DUT is ready
    task automatic send_off(input int n, input dat_t base, input bit isa);
        int i;
        int wait_cnt;
        for (i = 0; i < n; i++) begin
            @(negedge OffClk);
            off_dat_i      = base + dat_t'(i);
            off_dat_last_i = (i == n - 1);
            off_isa_vld_i  = isa;
            off_dat_vld_i  = 1'b1;
            wait_cnt = 0;
            #1;
            while (!off_dat_rdy_o && wait_cnt < TIMEOUT) begin
                @(negedge OffClk);
                #1;
                wait_cnt++;
            end
            if (wait_cnt >= TIMEOUT) begin
                $display("Timeout: %s off-chip port never took beat %0d", cur_name, i);
                err_cnt++;
                break;
            end
        end
        @(negedge OffClk);
        off_dat_vld_i  = 1'b0;
        off_dat_last_i = 1'b0;
    endtask

    // Core-side sender for the monitor or the gic outbound port
    task automatic send_core(input bit is_mon, input int n, input dat_t base, input bit cmd);
        int i;
        int wait_cnt;
        for (i = 0; i < n; i++) begin
            @(negedge core_clk);
            if (is_mon) begin
                mon_dat_i      = base + dat_t'(i);
                mon_dat_last_i = (i == n - 1);
                mon_dat_vld_i  = 1'b1;
            end else begin
                gic_dat_i      = base + dat_t'(i);
                gic_dat_last_i = (i == n - 1);
                gic_cmd_vld_i  = cmd;
                gic_dat_vld_i  = 1'b1;
            end
            wait_cnt = 0;
            #1;
            while (!(is_mon ? mon_dat_rdy_o : gic_dat_rdy_o) && wait_cnt < TIMEOUT) begin
                @(negedge core_clk);
                #1;
                wait_cnt++;
            end
            if (wait_cnt >= TIMEOUT) begin
                $display("Timeout: %s core port never took beat %0d", cur_name, i);
                err_cnt++;
                break;
            end
        end
        @(negedge core_clk);
        if (is_mon) begin
            mon_dat_vld_i  = 1'b0;
            mon_dat_last_i = 1'b0;
        end else begin
            gic_dat_vld_i  = 1'b0;
            gic_dat_last_i = 1'b0;
        end
    endtask

    task automatic wait_beats(input int src, input int start, input int n);
        int cnt;
        cnt = 0;
        while (collected_count(src) - start < n && cnt < TIMEOUT) begin
            @(negedge OffClk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: %s received only %0d of %0d beats", cur_name,
                     collected_count(src) - start, n);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Drive, collect and compare one table row

    task automatic run_row(input int r);
        entry_t exp_q[$];
        dat_t   base;
        int     n, i, src, start, errs0, ccu0, gic0, oe0;
        cur_name = t_name[r];
        base     = t_base[r];
        n        = t_beats[r];
        src      = t_src[r];
        errs0    = err_cnt;
        // Beat i carries base plus i and last marks the final beat
        for (i = 0; i < n; i++) begin
            if (src == MON_GIC) begin
                exp_q.push_back({base + dat_t'(i), 1'b0, i == n - 1});
            end else begin
                exp_q.push_back({base + dat_t'(i), src == GIC && t_cmd[r], i == n - 1});
            end
        end
        // Gic frame waits behind the monitor frame
        for (i = 0; i < n && src == MON_GIC; i++) begin
            exp_q.push_back({base + GIC_OFS + dat_t'(i), t_cmd[r], i == n - 1});
        end
        start = collected_count(src);
        ccu0  = ccu_vld_cnt;
        gic0  = gic_vld_cnt;
        oe0   = oe_bad_cnt;
        @(posedge OffClk);
        bp_en = t_bp[r];
        fork
            begin
                case (src)
                    OFF_CCU: send_off(n, base, 1'b1);
                    OFF_GIC: send_off(n, base, 1'b0);
                    GIC:     send_core(1'b0, n, base, t_cmd[r]);
                    MON:     send_core(1'b1, n, base, 1'b0);
                    default: begin
                        fork
                            send_core(1'b1, n, base, 1'b0);
                            send_core(1'b0, n, base + GIC_OFS, t_cmd[r]);
                        join
                    end
                endcase
            end
            wait_beats(src, start, exp_q.size());
        join
        @(posedge OffClk);
        bp_en = 1'b0;
        // Settle time so that a duplicated beat shows up in the count
        repeat (20) @(negedge OffClk);
        check_value("beat count", entry_t'(exp_q.size()), entry_t'(collected_count(src) - start));
        for (i = 0; i < exp_q.size() && start + i < collected_count(src); i++) begin
            check_value($sformatf("beat %0d", i), exp_q[i], beat_at(src, start + i));
        end
        if (t_dir[r] == DIR_OUT) begin
            check_value("oe mismatch cycles", '0, entry_t'(oe_bad_cnt - oe0));
        end else if (src == OFF_GIC) begin
            check_value("ccu valid cycles", '0, entry_t'(ccu_vld_cnt - ccu0));
        end else begin
            check_value("gic valid cycles", '0, entry_t'(gic_vld_cnt - gic0));
        end
        report_test(errs0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence

    initial begin
        rst_n          = 1'b0;
        off_dat_i      = '0;
        off_dat_vld_i  = 1'b0;
        off_dat_last_i = 1'b0;
        off_isa_vld_i  = 1'b0;
        gic_dat_i      = '0;
        gic_dat_vld_i  = 1'b0;
        gic_dat_last_i = 1'b0;
        gic_cmd_vld_i  = 1'b0;
        mon_dat_i      = '0;
        mon_dat_vld_i  = 1'b0;
        mon_dat_last_i = 1'b0;
        err_cnt        = 0;
        tests_run      = 0;
        tests_failed   = 0;

        add_row("in_gic",       DIR_IN,  OFF_GIC, 5,  32'h1000_0000, 1'b0, 1'b0);
        add_row("in_ccu",       DIR_IN,  OFF_CCU, 6,  32'h2000_0000, 1'b0, 1'b0);
        add_row("out_gic_cmd",  DIR_OUT, GIC,     4,  32'h3000_0000, 1'b1, 1'b0);
        add_row("out_mon",      DIR_OUT, MON,     4,  32'h3800_0000, 1'b1, 1'b0);
        add_row("mon_priority", DIR_OUT, MON_GIC, 3,  32'h4000_0000, 1'b1, 1'b0);
        add_row("bp_in_gic",    DIR_IN,  OFF_GIC, 20, 32'h5000_0000, 1'b0, 1'b1);
        add_row("bp_in_ccu",    DIR_IN,  OFF_CCU, 20, 32'h6000_0000, 1'b0, 1'b1);
        add_row("bp_out_gic",   DIR_OUT, GIC,     20, 32'h7000_0000, 1'b0, 1'b1);

        repeat (16) @(negedge OffClk);
        rst_n = 1'b1;
        @(negedge OffClk);
        #1;
        // Valids, readies and oe all low out of reset
        cur_name = "reset_state";
        check_value("vld/oe/rdy outputs", '0,
                    entry_t'({off_dat_vld_o, off_dat_oe_o, off_dat_rdy_o, ccu_dat_vld_o,
                              gic_dat_vld_o, gic_dat_rdy_o, mon_dat_rdy_o}));
        report_test(0);

        for (int r = 0; r < t_name.size(); r++) begin
            run_row(r);
        end

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/off_link_bridge.sv
// Off-chip link bridge top level
// Joins the OffClk side controller and the core side controller
// through one async FIFO per direction

`timescale 1ns/1ps

module off_link_bridge (
    input  logic                    OffClk,
    input  logic                    core_clk,
    input  logic                    rst_n,
    // Off-chip inbound
    input  off_link_pkg::link_dat_t off_dat_i,
    input  logic                    off_dat_vld_i,
    input  logic                    off_dat_last_i,
    input  logic                    off_isa_vld_i,
    output logic                    off_dat_rdy_o,
    // Off-chip outbound
    output off_link_pkg::link_dat_t off_dat_o,
    output logic                    off_dat_vld_o,
    output logic                    off_dat_last_o,
    output logic                    off_cmd_vld_o,
    output logic                    off_dat_oe_o,
    input  logic                    off_dat_rdy_i,
    // Instruction port
    output off_link_pkg::link_dat_t ccu_dat_o,
    output logic                    ccu_dat_vld_o,
    output logic                    ccu_dat_last_o,
    input  logic                    ccu_dat_rdy_i,
    // Global buffer
    output off_link_pkg::link_dat_t gic_dat_o,
    output logic                    gic_dat_vld_o,
    output logic                    gic_dat_last_o,
    input  logic                    gic_dat_rdy_i,
    input  off_link_pkg::link_dat_t gic_dat_i,
    input  logic                    gic_dat_vld_i,
    input  logic                    gic_dat_last_i,
    input  logic                    gic_cmd_vld_i,
    output logic                    gic_dat_rdy_o,
    // Monitor
    input  off_link_pkg::link_dat_t mon_dat_i,
    input  logic                    mon_dat_vld_i,
    input  logic                    mon_dat_last_i,
    output logic                    mon_dat_rdy_o
);

    // In-to-chip FIFO
    logic                      in_push, in_full, in_pop, in_empty;
    off_link_pkg::fifo_entry_t in_wr_entry, in_rd_entry;

    // Out-to-off FIFO
    logic                      out_push, out_full, out_pop, out_empty;
    off_link_pkg::fifo_entry_t out_wr_entry, out_rd_entry;

    // ------------------------------------------------------------------------
    // OffClk domain

    off_link_ctrl u_off_link_ctrl (
        .OffClk         (OffClk),
        .rst_n          (rst_n),
        .off_dat_i      (off_dat_i),
        .off_dat_vld_i  (off_dat_vld_i),
        .off_dat_last_i (off_dat_last_i),
        .off_isa_vld_i  (off_isa_vld_i),
        .off_dat_rdy_o  (off_dat_rdy_o),
        .off_dat_o      (off_dat_o),
        .off_dat_vld_o  (off_dat_vld_o),
        .off_dat_last_o (off_dat_last_o),
        .off_cmd_vld_o  (off_cmd_vld_o),
        .off_dat_oe_o   (off_dat_oe_o),
        .off_dat_rdy_i  (off_dat_rdy_i),
        .in_push_o      (in_push),
        .in_entry_o     (in_wr_entry),
        .in_full_i      (in_full),
        .out_entry_i    (out_rd_entry),
        .out_empty_i    (out_empty),
        .out_pop_o      (out_pop)
    );

    // ------------------------------------------------------------------------
    // Clock crossing

    async_fifo_fwft #(
        .DATA_W (off_link_pkg::ENTRY_W),
        .ADDR_W (off_link_pkg::FIFO_AW)
    ) u_fifo_in2chip (
        .wr_clk_i (OffClk),
        .rd_clk_i (core_clk),
        .rst_n    (rst_n),
        .push_i   (in_push),
        .din_i    (in_wr_entry),
        .full_o   (in_full),
        .pop_i    (in_pop),
        .dout_o   (in_rd_entry),
        .empty_o  (in_empty)
    );

    async_fifo_fwft #(
        .DATA_W (off_link_pkg::ENTRY_W),
        .ADDR_W (off_link_pkg::FIFO_AW)
    ) u_fifo_out2off (
        .wr_clk_i (core_clk),
        .rd_clk_i (OffClk),
        .rst_n    (rst_n),
        .push_i   (out_push),
        .din_i    (out_wr_entry),
        .full_o   (out_full),
        .pop_i    (out_pop),
        .dout_o   (out_rd_entry),
        .empty_o  (out_empty)
    );

    // ------------------------------------------------------------------------
    // Core clock domain

    core_link_ctrl u_core_link_ctrl (
        .core_clk       (core_clk),
        .rst_n          (rst_n),
        .in_entry_i     (in_rd_entry),
        .in_empty_i     (in_empty),
        .in_pop_o       (in_pop),
        .ccu_dat_o      (ccu_dat_o),
        .ccu_dat_vld_o  (ccu_dat_vld_o),
        .ccu_dat_last_o (ccu_dat_last_o),
        .ccu_dat_rdy_i  (ccu_dat_rdy_i),
        .gic_dat_o      (gic_dat_o),
        .gic_dat_vld_o  (gic_dat_vld_o),
        .gic_dat_last_o (gic_dat_last_o),
        .gic_dat_rdy_i  (gic_dat_rdy_i),
        .gic_dat_i      (gic_dat_i),
        .gic_dat_vld_i  (gic_dat_vld_i),
        .gic_dat_last_i (gic_dat_last_i),
        .gic_cmd_vld_i  (gic_cmd_vld_i),
        .gic_dat_rdy_o  (gic_dat_rdy_o),
        .mon_dat_i      (mon_dat_i),
        .mon_dat_vld_i  (mon_dat_vld_i),
        .mon_dat_last_i (mon_dat_last_i),
        .mon_dat_rdy_o  (mon_dat_rdy_o),
        .out_push_o     (out_push),
        .out_entry_o    (out_wr_entry),
        .out_full_i     (out_full)
    );

endmodule

//--- verilog/core_link_ctrl.sv
// Core side link controller
// Direction FSM in the core clock domain. Inbound FIFO beats are
// steered to ccu or gic by their instruction flag. Outbound frames
// come from the monitor or gic, one whole frame at a time, monitor first

`timescale 1ns/1ps

module core_link_ctrl (
    input  logic                      core_clk,
    input  logic                      rst_n,
    // In-to-chip FIFO read side
    input  off_link_pkg::fifo_entry_t in_entry_i,
    input  logic                      in_empty_i,
    output logic                      in_pop_o,
    // Instruction port
    output off_link_pkg::link_dat_t   ccu_dat_o,
    output logic                      ccu_dat_vld_o,
    output logic                      ccu_dat_last_o,
    input  logic                      ccu_dat_rdy_i,
    // Global buffer inbound
    output off_link_pkg::link_dat_t   gic_dat_o,
    output logic                      gic_dat_vld_o,
    output logic                      gic_dat_last_o,
    input  logic                      gic_dat_rdy_i,
    // Global buffer outbound
    input  off_link_pkg::link_dat_t   gic_dat_i,
    input  logic                      gic_dat_vld_i,
    input  logic                      gic_dat_last_i,
    input  logic                      gic_cmd_vld_i,
    output logic                      gic_dat_rdy_o,
    // Monitor outbound
    input  off_link_pkg::link_dat_t   mon_dat_i,
    input  logic                      mon_dat_vld_i,
    input  logic                      mon_dat_last_i,
    output logic                      mon_dat_rdy_o,
    // Out-to-off FIFO write side
    output logic                      out_push_o,
    output off_link_pkg::fifo_entry_t out_entry_o,
    input  logic                      out_full_i
);

    link_fsm_pkg::link_dir_e state_q, state_d;
    link_fsm_pkg::out_src_e  src_q, src_d;
    logic                    in_act, in_isa, in_last, out_act, out_last;

    // ------------------------------------------------------------------------
    // Direction FSM and source latch

    always_comb begin
        state_d = state_q;
        src_d   = src_q;
        case (state_q)
            link_fsm_pkg::LINK_IDLE: begin
                if (!in_empty_i) begin
                    state_d = link_fsm_pkg::LINK_IN2CHIP;
                end else if (mon_dat_vld_i || gic_dat_vld_i) begin
                    state_d = link_fsm_pkg::LINK_OUT2OFF;
                    src_d   = mon_dat_vld_i ? link_fsm_pkg::SRC_MON : link_fsm_pkg::SRC_GIC;
                end
            end
            link_fsm_pkg::LINK_IN2CHIP: begin
                if (in_pop_o && in_last) begin
                    state_d = link_fsm_pkg::LINK_IDLE;
                end
            end
            link_fsm_pkg::LINK_OUT2OFF: begin
                if (out_push_o && out_last) begin
                    state_d = link_fsm_pkg::LINK_IDLE;
                end
            end
            default: state_d = link_fsm_pkg::LINK_IDLE;
        endcase
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= link_fsm_pkg::LINK_IDLE;
            src_q   <= link_fsm_pkg::SRC_MON;
        end else begin
            state_q <= state_d;
            src_q   <= src_d;
        end
    end

    // ------------------------------------------------------------------------
    // Inbound routing by instruction flag

    assign in_act  = (state_q == link_fsm_pkg::LINK_IN2CHIP) & ~in_empty_i;
    assign in_isa  = in_entry_i[off_link_pkg::ENT_FLAG];
    assign in_last = in_entry_i[off_link_pkg::ENT_LAST];

    assign ccu_dat_o      = in_entry_i[off_link_pkg::ENTRY_W-1 -: off_link_pkg::DAT_W];
    assign ccu_dat_vld_o  = in_act & in_isa;
    assign ccu_dat_last_o = in_act & in_isa & in_last;

    assign gic_dat_o      = in_entry_i[off_link_pkg::ENTRY_W-1 -: off_link_pkg::DAT_W];
    assign gic_dat_vld_o  = in_act & ~in_isa;
    assign gic_dat_last_o = in_act & ~in_isa & in_last;

    // Pop once the selected sink takes the head
    assign in_pop_o = (ccu_dat_vld_o & ccu_dat_rdy_i) | (gic_dat_vld_o & gic_dat_rdy_i);

    // ------------------------------------------------------------------------
    // Outbound, only the latched source sees ready

    assign out_act = (state_q == link_fsm_pkg::LINK_OUT2OFF) & ~out_full_i;

    assign mon_dat_rdy_o = out_act & (src_q == link_fsm_pkg::SRC_MON);
    assign gic_dat_rdy_o = out_act & (src_q == link_fsm_pkg::SRC_GIC);

    assign out_push_o = (mon_dat_vld_i & mon_dat_rdy_o) | (gic_dat_vld_i & gic_dat_rdy_o);

    // Monitor beats never carry a command
    assign out_entry_o = (src_q == link_fsm_pkg::SRC_MON) ?
                         {mon_dat_i, 1'b0, mon_dat_last_i} :
                         {gic_dat_i, gic_cmd_vld_i, gic_dat_last_i};
    assign out_last    = out_entry_o[off_link_pkg::ENT_LAST];

endmodule

//--- verilog/off_link_ctrl.sv
// Off-chip side link controller
// Direction FSM in the OffClk domain. Inbound beats are pushed into
// the in-to-chip FIFO, outbound beats are popped from the out-to-off
// FIFO and driven onto the off-chip port

`timescale 1ns/1ps

module off_link_ctrl (
    input  logic                      OffClk,
    input  logic                      rst_n,
    // Off-chip inbound
    input  off_link_pkg::link_dat_t   off_dat_i,
    input  logic                      off_dat_vld_i,
    input  logic                      off_dat_last_i,
    input  logic                      off_isa_vld_i,
    output logic                      off_dat_rdy_o,
    // Off-chip outbound
    output off_link_pkg::link_dat_t   off_dat_o,
    output logic                      off_dat_vld_o,
    output logic                      off_dat_last_o,
    output logic                      off_cmd_vld_o,
    output logic                      off_dat_oe_o,
    input  logic                      off_dat_rdy_i,
    // In-to-chip FIFO write side
    output logic                      in_push_o,
    output off_link_pkg::fifo_entry_t in_entry_o,
    input  logic                      in_full_i,
    // Out-to-off FIFO read side
    input  off_link_pkg::fifo_entry_t out_entry_i,
    input  logic                      out_empty_i,
    output logic                      out_pop_o
);

    link_fsm_pkg::link_dir_e state_q, state_d;
    logic                    in_xfer, out_xfer, out_vld;

    // ------------------------------------------------------------------------
    // Direction FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            link_fsm_pkg::LINK_IDLE: begin
                if (off_dat_vld_i) begin
                    state_d = link_fsm_pkg::LINK_IN2CHIP;
                end else if (!out_empty_i) begin
                    state_d = link_fsm_pkg::LINK_OUT2OFF;
                end
            end
            link_fsm_pkg::LINK_IN2CHIP: begin
                if (in_xfer && off_dat_last_i) begin
                    state_d = link_fsm_pkg::LINK_IDLE;
                end
            end
            link_fsm_pkg::LINK_OUT2OFF: begin
                if (out_xfer && off_dat_last_o) begin
                    state_d = link_fsm_pkg::LINK_IDLE;
                end
            end
            default: state_d = link_fsm_pkg::LINK_IDLE;
        endcase
    end

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= link_fsm_pkg::LINK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // Inbound, accept while the FIFO has room

    assign off_dat_rdy_o = (state_q == link_fsm_pkg::LINK_IN2CHIP) & ~in_full_i;
    assign in_xfer       = off_dat_vld_i & off_dat_rdy_o;
    assign in_push_o     = in_xfer;
    assign in_entry_o    = {off_dat_i, off_isa_vld_i, off_dat_last_i};

    // ------------------------------------------------------------------------
    // Outbound, unpack the FIFO head

    assign out_vld        = (state_q == link_fsm_pkg::LINK_OUT2OFF) & ~out_empty_i;
    assign out_xfer       = out_vld & off_dat_rdy_i;
    assign out_pop_o      = out_xfer;
    assign off_dat_o      = out_entry_i[off_link_pkg::ENTRY_W-1 -: off_link_pkg::DAT_W];
    assign off_dat_last_o = out_vld & out_entry_i[off_link_pkg::ENT_LAST];
    assign off_cmd_vld_o  = out_vld & out_entry_i[off_link_pkg::ENT_FLAG];
    assign off_dat_vld_o  = out_vld;

    // Pads drive only while outbound data is valid
    assign off_dat_oe_o = out_vld;

endmodule

//--- verilog/async_fifo_fwft.sv
// Dual-clock first-word-fall-through FIFO
// Binary pointers address the memory, Gray copies cross the clock
// domains through two-flop synchronizers. The head entry is visible
// on dout_o whenever the FIFO is not empty

`timescale 1ns/1ps

module async_fifo_fwft #(
    parameter int DATA_W = 34,
    parameter int ADDR_W = 4
) (
    input  logic              wr_clk_i,
    input  logic              rd_clk_i,
    input  logic              rst_n,
    input  logic              push_i,
    input  logic [DATA_W-1:0] din_i,
    output logic              full_o,
    input  logic              pop_i,
    output logic [DATA_W-1:0] dout_o,
    output logic              empty_o
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    logic [ADDR_W:0] wr_bin_q, wr_bin_d, wr_gray_q, wr_gray_d;
    logic [ADDR_W:0] rd_bin_q, rd_bin_d, rd_gray_q, rd_gray_d;
    logic [ADDR_W:0] rd_gray_s1, rd_gray_s2;
    logic [ADDR_W:0] wr_gray_s1, wr_gray_s2;
    logic            wr_en, rd_en;

    // ------------------------------------------------------------------------
    // Write domain

    assign wr_en     = push_i & ~full_o;
    assign wr_bin_d  = wr_bin_q + {{ADDR_W{1'b0}}, wr_en};
    assign wr_gray_d = (wr_bin_d >> 1) ^ wr_bin_d;

    always_ff @(posedge wr_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin_q   <= '0;
            wr_gray_q  <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            wr_bin_q   <= wr_bin_d;
            wr_gray_q  <= wr_gray_d;
            rd_gray_s1 <= rd_gray_q;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_en) begin
            mem[wr_bin_q[ADDR_W-1:0]] <= din_i;
        end
    end

    // Full when the write pointer is one lap ahead of the read pointer
    assign full_o = (wr_gray_q == {~rd_gray_s2[ADDR_W:ADDR_W-1], rd_gray_s2[ADDR_W-2:0]});

    // ------------------------------------------------------------------------
    // Read domain

    assign rd_en     = pop_i & ~empty_o;
    assign rd_bin_d  = rd_bin_q + {{ADDR_W{1'b0}}, rd_en};
    assign rd_gray_d = (rd_bin_d >> 1) ^ rd_bin_d;

    always_ff @(posedge rd_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin_q   <= '0;
            rd_gray_q  <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin_q   <= rd_bin_d;
            rd_gray_q  <= rd_gray_d;
            wr_gray_s1 <= wr_gray_q;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign empty_o = (rd_gray_q == wr_gray_s2);

    // Head entry falls through
    assign dout_o = mem[rd_bin_q[ADDR_W-1:0]];

endmodule

//--- verilog/link_fsm_pkg.sv
// Direction and source types for the link controllers
// Both clock domains step through the same three direction states

package link_fsm_pkg;

    // Transfer direction of the half-duplex link
    typedef enum logic [1:0] {
        LINK_IDLE    = 2'd0,
        LINK_IN2CHIP = 2'd1,
        LINK_OUT2OFF = 2'd2
    } link_dir_e;

    // Outbound frame owner, monitor wins a tie
    typedef enum logic {
        SRC_MON = 1'b0,
        SRC_GIC = 1'b1
    } out_src_e;

endpackage

//--- verilog/off_link_pkg.sv
// Off-chip link bridge data definitions
// Beat width, async FIFO depth and the packed FIFO entry layout
// An entry is {data, flag, last} with last in bit 0

package off_link_pkg;

    // Beat and FIFO geometry
    localparam int DAT_W   = 32;
    localparam int FIFO_AW = 4;
    localparam int ENTRY_W = DAT_W + 2;

    // Entry bit positions
    localparam int ENT_LAST = 0;
    localparam int ENT_FLAG = 1;

    // One data beat on either side of the link
    typedef logic [DAT_W-1:0] link_dat_t;

    // Beat plus flag (instruction inbound, command outbound) plus last
    typedef logic [ENTRY_W-1:0] fifo_entry_t;

endpackage
